//--- verilog/l1d_config.svh
/*
 * L1D front end configuration
 * Cache geometry, word widths and the read client port map
 */
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Address and data widths
`define L1D_PADDR_W 32
`define L1D_XLEN_W  32
`define L1D_LINE_W  128

// Geometry
`define L1D_SETS 16
`define L1D_WAYS 2

// Read clients, lowest index has highest priority
`define L1D_RD_PORT_NUM 3
`define L1D_SNOOP_PORT  0
`define L1D_PTW_PORT    1
`define L1D_LOAD_PORT   2

`endif

//--- verilog/l1d_cache_pkg.sv
/*
 * L1D cache-side types
 * Addresses, read/write requests, read responses and lookup status
 */
`include "l1d_config.svh"

package l1d_cache_pkg;

  // Address split: | tag | index | offset |
  localparam int OFFSET_W = $clog2(`L1D_LINE_W / 8);
  localparam int INDEX_W  = $clog2(`L1D_SETS);
  localparam int TAG_W    = `L1D_PADDR_W - INDEX_W - OFFSET_W;

  typedef logic [`L1D_PADDR_W-1:0] paddr_t;
  typedef logic [`L1D_WAYS-1:0]    way_oh_t;
  typedef logic [`L1D_LINE_W-1:0]  line_t;

  typedef enum logic [1:0] {
    STATUS_NONE     = 2'd0,
    STATUS_HIT      = 2'd1,
    STATUS_MISS     = 2'd2,
    STATUS_CONFLICT = 2'd3
  } status_e;

  // s0 read request from one client
  typedef struct packed {
    logic   valid;
    paddr_t paddr;
  } rd_req_t;

  // s1 read response to one client
  typedef struct packed {
    status_e status;
    way_oh_t hit_way;
    line_t   line;
  } rd_resp_t;

  // Line write, refill sets line_valid and invalidate clears it
  typedef struct packed {
    paddr_t  paddr;
    way_oh_t way;
    line_t   data;
    logic    line_valid;
  } wr_req_t;

endpackage

//--- verilog/l1d_snoop_pkg.sv
/*
 * L1D external client types
 * Snoop commands and the snoop and page-table-walker port structs
 */
`include "l1d_config.svh"

package l1d_snoop_pkg;

  // One byte enable bit per line byte
  localparam int LINE_BE_W = `L1D_LINE_W / 8;

  typedef enum logic [1:0] {
    SNOOP_READ    = 2'd0,
    SNOOP_INVALID = 2'd1
  } snoop_cmd_e;

  typedef struct packed {
    logic                  valid;
    snoop_cmd_e            cmd;
    l1d_cache_pkg::paddr_t  paddr;
    l1d_cache_pkg::way_oh_t way;
  } snoop_req_t;

  typedef struct packed {
    logic                   valid;
    l1d_cache_pkg::status_e status;
    l1d_cache_pkg::way_oh_t way;
    logic [LINE_BE_W-1:0]   be;
    l1d_cache_pkg::line_t   line;
  } snoop_resp_t;

  // Walker access, one word back per request
  typedef struct packed {
    logic                  valid;
    l1d_cache_pkg::paddr_t paddr;
  } ptw_req_t;

  typedef struct packed {
    logic                   valid;
    l1d_cache_pkg::status_e status;
    logic [`L1D_XLEN_W-1:0] word;
  } ptw_resp_t;

endpackage

//--- verilog/l1d_rd_arbiter.sv
/*
 * L1D read and write port arbiter
 * Fixed-priority grant of one read per cycle with s1 response steering,
 * and selection of the single array write between invalidate and refill
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_rd_arbiter (
  input  logic                     i_clk,
  input  logic                     i_reset_n,
  input  l1d_cache_pkg::rd_req_t   i_rd_req [`L1D_RD_PORT_NUM],
  output l1d_cache_pkg::rd_resp_t  o_rd_resp [`L1D_RD_PORT_NUM],
  output l1d_cache_pkg::rd_req_t   o_arr_req,
  input  logic                     i_arr_hit,
  input  l1d_cache_pkg::way_oh_t   i_arr_way,
  input  l1d_cache_pkg::line_t     i_arr_line,
  input  logic                     i_inval_valid,
  input  l1d_cache_pkg::wr_req_t   i_inval,
  input  logic                     i_refill_valid,
  input  l1d_cache_pkg::wr_req_t   i_refill,
  output logic                     o_refill_ready,
  output logic                     o_arr_wr_valid,
  output l1d_cache_pkg::wr_req_t   o_arr_wr
);

  logic [`L1D_RD_PORT_NUM-1:0] w_req_valid;
  logic [`L1D_RD_PORT_NUM-1:0] w_grant;
  logic [`L1D_RD_PORT_NUM-1:0] r_grant;
  logic [`L1D_RD_PORT_NUM-1:0] r_req;

  // ----------------------------------------
  // s0 grant
  // ----------------------------------------
  always_comb begin
    for (int p = 0; p < `L1D_RD_PORT_NUM; p++) begin
      w_req_valid[p] = i_rd_req[p].valid;
    end
  end

  // Isolate the lowest set bit
  assign w_grant = w_req_valid & (~w_req_valid + 1'b1);

  always_comb begin
    o_arr_req = '0;
    for (int p = 0; p < `L1D_RD_PORT_NUM; p++) begin
      if (w_grant[p]) begin
        o_arr_req = i_rd_req[p];
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_grant <= '0;
      r_req   <= '0;
    end else begin
      r_grant <= w_grant;
      r_req   <= w_req_valid;
    end
  end

  // ----------------------------------------
  // s1 response steering
  // ----------------------------------------
  always_comb begin
    for (int p = 0; p < `L1D_RD_PORT_NUM; p++) begin
      o_rd_resp[p].hit_way = i_arr_way;
      o_rd_resp[p].line    = i_arr_line;
      if (r_grant[p]) begin
        o_rd_resp[p].status = i_arr_hit ? l1d_cache_pkg::STATUS_HIT
                                        : l1d_cache_pkg::STATUS_MISS;
      end else if (r_req[p]) begin
        o_rd_resp[p].status = l1d_cache_pkg::STATUS_CONFLICT;
      end else begin
        o_rd_resp[p].status = l1d_cache_pkg::STATUS_NONE;
      end
    end
  end

  // Invalidate owns the write port, refill waits
  assign o_refill_ready = ~i_inval_valid;
  assign o_arr_wr_valid = i_inval_valid | i_refill_valid;
  assign o_arr_wr       = i_inval_valid ? i_inval : i_refill;

  // At most one winner, and only among last cycle's requesters
  a_grant_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(r_grant) && ((r_grant & ~r_req) == '0));

endmodule

//--- verilog/l1d_array.sv
/*
 * L1D tag, valid and data storage
 * Two-way lookup registered into s1, one write port for refill/invalidate
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_array (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  input  l1d_cache_pkg::rd_req_t i_rd_req,
  output logic                   o_hit,
  output l1d_cache_pkg::way_oh_t o_hit_way,
  output l1d_cache_pkg::line_t   o_line,
  input  logic                   i_wr_valid,
  input  l1d_cache_pkg::wr_req_t i_wr
);

  localparam int OFF_W = l1d_cache_pkg::OFFSET_W;
  localparam int IDX_W = l1d_cache_pkg::INDEX_W;
  localparam int TAG_W = l1d_cache_pkg::TAG_W;

  logic [TAG_W-1:0]     r_tag   [`L1D_SETS][`L1D_WAYS];
  l1d_cache_pkg::line_t r_data  [`L1D_SETS][`L1D_WAYS];
  logic [`L1D_WAYS-1:0] r_valid [`L1D_SETS];

  logic [IDX_W-1:0]       w_rd_idx;
  logic [TAG_W-1:0]       w_rd_tag;
  logic [IDX_W-1:0]       w_wr_idx;
  logic [TAG_W-1:0]       w_wr_tag;
  l1d_cache_pkg::way_oh_t w_way_hit;
  l1d_cache_pkg::line_t   w_hit_line;

  logic                   r_hit;
  l1d_cache_pkg::way_oh_t r_hit_way;
  l1d_cache_pkg::line_t   r_line;

  assign w_rd_idx = i_rd_req.paddr[OFF_W +: IDX_W];
  assign w_rd_tag = i_rd_req.paddr[`L1D_PADDR_W-1 -: TAG_W];
  assign w_wr_idx = i_wr.paddr[OFF_W +: IDX_W];
  assign w_wr_tag = i_wr.paddr[`L1D_PADDR_W-1 -: TAG_W];

  // ----------------------------------------
  // s0 lookup
  // ----------------------------------------
  always_comb begin
    w_hit_line = '0;
    for (int w = 0; w < `L1D_WAYS; w++) begin
      w_way_hit[w] = i_rd_req.valid & r_valid[w_rd_idx][w] &
                     (r_tag[w_rd_idx][w] == w_rd_tag);
      if (w_way_hit[w]) begin
        w_hit_line = r_data[w_rd_idx][w];
      end
    end
  end

  // Registered into s1, old contents win over a same-edge write
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_hit     <= 1'b0;
      r_hit_way <= '0;
    end else begin
      r_hit     <= |w_way_hit;
      r_hit_way <= w_way_hit;
    end
  end

  always_ff @(posedge i_clk) begin
    r_line <= w_hit_line;
  end

  assign o_hit     = r_hit;
  assign o_hit_way = r_hit_way;
  assign o_line    = r_line;

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int s = 0; s < `L1D_SETS; s++) begin
        r_valid[s] <= '0;
      end
    end else if (i_wr_valid) begin
      for (int w = 0; w < `L1D_WAYS; w++) begin
        if (i_wr.way[w]) begin
          r_valid[w_wr_idx][w] <= i_wr.line_valid;
        end
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      for (int w = 0; w < `L1D_WAYS; w++) begin
        if (i_wr.way[w]) begin
          r_tag[w_wr_idx][w]  <= w_wr_tag;
          r_data[w_wr_idx][w] <= i_wr.data;
        end
      end
    end
  end

  // Refill source and snooper must name exactly one way
  a_wr_way_onehot: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_wr_valid |-> $onehot(i_wr.way));

endmodule

//--- verilog/l1d_ptw_access.sv
/*
 * L1D walker access adapter
 * Issues walker reads on its port and returns one word of the line
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_ptw_access (
  input  logic                      i_clk,
  input  logic                      i_reset_n,
  input  l1d_snoop_pkg::ptw_req_t   i_ptw_req,
  output l1d_snoop_pkg::ptw_resp_t  o_ptw_resp,
  output l1d_cache_pkg::rd_req_t    o_rd_req,
  input  l1d_cache_pkg::rd_resp_t   i_rd_resp
);

  // Word index within the line, paddr[3:2] for this geometry
  localparam int SEL_W   = $clog2(`L1D_LINE_W / `L1D_XLEN_W);
  localparam int SEL_LSB = $clog2(`L1D_XLEN_W / 8);

  logic             r_resp_valid;
  logic [SEL_W-1:0] r_word_sel;

  assign o_rd_req.valid = i_ptw_req.valid;
  assign o_rd_req.paddr = i_ptw_req.paddr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_ptw_req.valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_word_sel <= i_ptw_req.paddr[SEL_LSB +: SEL_W];
  end

  // s1 result
  assign o_ptw_resp.valid  = r_resp_valid;
  assign o_ptw_resp.status = i_rd_resp.status;
  assign o_ptw_resp.word   = i_rd_resp.line[r_word_sel * `L1D_XLEN_W +: `L1D_XLEN_W];

endmodule

//--- verilog/l1d_snoop_unit.sv
/*
 * L1D snoop adapter
 * Turns snoop reads into cache reads and snoop invalidates into writes
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_snoop_unit (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  l1d_snoop_pkg::snoop_req_t   i_snoop_req,
  output l1d_snoop_pkg::snoop_resp_t  o_snoop_resp,
  output l1d_cache_pkg::rd_req_t      o_rd_req,
  input  l1d_cache_pkg::rd_resp_t     i_rd_resp,
  output logic                        o_inval_valid,
  output l1d_cache_pkg::wr_req_t      o_inval
);

  logic r_resp_valid;
  logic w_is_read;
  logic w_is_inval;

  assign w_is_read  = i_snoop_req.valid & (i_snoop_req.cmd == l1d_snoop_pkg::SNOOP_READ);
  assign w_is_inval = i_snoop_req.valid & (i_snoop_req.cmd == l1d_snoop_pkg::SNOOP_INVALID);

  assign o_rd_req.valid = w_is_read;
  assign o_rd_req.paddr = i_snoop_req.paddr;

  // Invalidate clears valid and data of the named way
  assign o_inval_valid      = w_is_inval;
  assign o_inval.paddr      = i_snoop_req.paddr;
  assign o_inval.way        = i_snoop_req.way;
  assign o_inval.data       = '0;
  assign o_inval.line_valid = 1'b0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_resp_valid <= 1'b0;
    end else begin
      r_resp_valid <= i_snoop_req.valid;
    end
  end

  // Invalidate made no read, so its port reports NONE
  assign o_snoop_resp.valid  = r_resp_valid;
  assign o_snoop_resp.status = i_rd_resp.status;
  assign o_snoop_resp.way    = i_rd_resp.hit_way;
  assign o_snoop_resp.be     = (i_rd_resp.status == l1d_cache_pkg::STATUS_HIT) ? '1 : '0;
  assign o_snoop_resp.line   = i_rd_resp.line;

  a_snoop_cmd_known: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_snoop_req.valid |->
      i_snoop_req.cmd inside {l1d_snoop_pkg::SNOOP_READ, l1d_snoop_pkg::SNOOP_INVALID});

endmodule

//--- verilog/l1d_top.sv
/*
 * L1D data cache front end
 * Snoop, walker and load read ports plus refill, around a 2-way array
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_top (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  l1d_cache_pkg::rd_req_t      i_load_req,
  output l1d_cache_pkg::rd_resp_t     o_load_resp,
  input  l1d_snoop_pkg::ptw_req_t     i_ptw_req,
  output l1d_snoop_pkg::ptw_resp_t    o_ptw_resp,
  input  l1d_snoop_pkg::snoop_req_t   i_snoop_req,
  output l1d_snoop_pkg::snoop_resp_t  o_snoop_resp,
  input  logic                        i_refill_valid,
  input  l1d_cache_pkg::wr_req_t      i_refill,
  output logic                        o_refill_ready
);

  l1d_cache_pkg::rd_req_t  w_rd_req  [`L1D_RD_PORT_NUM];
  l1d_cache_pkg::rd_resp_t w_rd_resp [`L1D_RD_PORT_NUM];

  l1d_cache_pkg::rd_req_t  w_arr_req;
  logic                    w_arr_hit;
  l1d_cache_pkg::way_oh_t  w_arr_way;
  l1d_cache_pkg::line_t    w_arr_line;
  logic                    w_inval_valid;
  l1d_cache_pkg::wr_req_t  w_inval;
  logic                    w_arr_wr_valid;
  l1d_cache_pkg::wr_req_t  w_arr_wr;

  // Load client connects straight to its port
  assign w_rd_req[`L1D_LOAD_PORT] = i_load_req;
  assign o_load_resp              = w_rd_resp[`L1D_LOAD_PORT];

  // ----------------------------------------
  // Client adapters
  // ----------------------------------------
  l1d_ptw_access u_ptw_access (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_ptw_req  (i_ptw_req),
    .o_ptw_resp (o_ptw_resp),
    .o_rd_req   (w_rd_req[`L1D_PTW_PORT]),
    .i_rd_resp  (w_rd_resp[`L1D_PTW_PORT])
  );

  l1d_snoop_unit u_snoop_unit (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_snoop_req   (i_snoop_req),
    .o_snoop_resp  (o_snoop_resp),
    .o_rd_req      (w_rd_req[`L1D_SNOOP_PORT]),
    .i_rd_resp     (w_rd_resp[`L1D_SNOOP_PORT]),
    .o_inval_valid (w_inval_valid),
    .o_inval       (w_inval)
  );

  // ----------------------------------------
  // Arbitration and storage
  // ----------------------------------------
  l1d_rd_arbiter u_rd_arbiter (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_rd_req       (w_rd_req),
    .o_rd_resp      (w_rd_resp),
    .o_arr_req      (w_arr_req),
    .i_arr_hit      (w_arr_hit),
    .i_arr_way      (w_arr_way),
    .i_arr_line     (w_arr_line),
    .i_inval_valid  (w_inval_valid),
    .i_inval        (w_inval),
    .i_refill_valid (i_refill_valid),
    .i_refill       (i_refill),
    .o_refill_ready (o_refill_ready),
    .o_arr_wr_valid (w_arr_wr_valid),
    .o_arr_wr       (w_arr_wr)
  );

  l1d_array u_array (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_rd_req   (w_arr_req),
    .o_hit      (w_arr_hit),
    .o_hit_way  (w_arr_way),
    .o_line     (w_arr_line),
    .i_wr_valid (w_arr_wr_valid),
    .i_wr       (w_arr_wr)
  );

endmodule

//--- tests/l1d_tests.svh
/*
 * L1D front end directed tests
 * Reset, refill, walker word select, read arbitration and invalidate
 */

task automatic test_reset_state();
  @(negedge clk);
  check_bit("o_snoop_resp.valid", snoop_resp.valid, 1'b0);
  check_bit("o_ptw_resp.valid", ptw_resp.valid, 1'b0);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_NONE);
  check_bit("o_refill_ready", refill_ready, 1'b1);
  // Nothing is valid yet, so any address misses
  load_read(lcg_next());
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_MISS);
endtask

task automatic test_refill_then_load();
  line_a_addr = lcg_next() & 32'hffff_fff0;
  line_a_data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};
  start_refill(make_refill(line_a_addr, 2'b10, line_a_data));
  finish_refill();
  load_read(line_a_addr);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_HIT);
  check_way("o_load_resp.hit_way", load_resp.hit_way, 2'b10);
  check_line("o_load_resp.line", load_resp.line, line_a_data);
endtask

task automatic test_walker_word();
  for (int k = 0; k < 4; k++) begin
    ptw_read(line_a_addr + k * 4);
    check_status("o_ptw_resp.status", ptw_resp.status, l1d_cache_pkg::STATUS_HIT);
    check_word("o_ptw_resp.word", ptw_resp.word, line_a_data[k*32 +: 32]);
  end
  // Same set, different tag, way 0 still empty
  ptw_read(line_a_addr ^ 32'h8000_0000);
  check_status("o_ptw_resp.status", ptw_resp.status, l1d_cache_pkg::STATUS_MISS);
endtask

task automatic test_arbitration();
  issue_reads(make_snoop(l1d_snoop_pkg::SNOOP_READ, line_a_addr, '0),
              make_ptw(line_a_addr), make_rd(line_a_addr));
  check_status("o_snoop_resp.status", snoop_resp.status, l1d_cache_pkg::STATUS_HIT);
  check_word("o_snoop_resp.be", {16'd0, snoop_resp.be}, 32'h0000_ffff);
  check_way("o_snoop_resp.way", snoop_resp.way, 2'b10);
  check_line("o_snoop_resp.line", snoop_resp.line, line_a_data);
  check_status("o_ptw_resp.status", ptw_resp.status, l1d_cache_pkg::STATUS_CONFLICT);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_CONFLICT);

  // Without a snoop the walker wins
  issue_reads('0, make_ptw(line_a_addr + 32'd4), make_rd(line_a_addr));
  check_status("o_ptw_resp.status", ptw_resp.status, l1d_cache_pkg::STATUS_HIT);
  check_word("o_ptw_resp.word", ptw_resp.word, line_a_data[63:32]);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_CONFLICT);
  check_status("o_snoop_resp.status", snoop_resp.status, l1d_cache_pkg::STATUS_NONE);
endtask

task automatic test_invalidate_refill();
  l1d_cache_pkg::paddr_t line_b_addr;
  l1d_cache_pkg::line_t  line_b_data;
  line_b_addr = lcg_next() & 32'hffff_fff0;
  if (line_b_addr[31:8] == line_a_addr[31:8]) begin
    line_b_addr = line_b_addr ^ 32'h8000_0000;
  end
  line_b_data = {lcg_next(), lcg_next(), lcg_next(), lcg_next()};

  // Invalidate and refill presented together
  @(posedge clk);
  snoop_req    <= make_snoop(l1d_snoop_pkg::SNOOP_INVALID, line_a_addr, 2'b10);
  refill_valid <= 1'b1;
  refill       <= make_refill(line_b_addr, 2'b01, line_b_data);
  @(negedge clk);
  check_bit("o_refill_ready", refill_ready, 1'b0);
  @(posedge clk);
  snoop_req <= '0;
  @(negedge clk);
  check_bit("o_snoop_resp.valid", snoop_resp.valid, 1'b1);
  check_status("o_snoop_resp.status", snoop_resp.status, l1d_cache_pkg::STATUS_NONE);
  check_bit("o_refill_ready", refill_ready, 1'b1);
  finish_refill();

  load_read(line_a_addr);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_MISS);
  snoop_read(line_a_addr);
  check_status("o_snoop_resp.status", snoop_resp.status, l1d_cache_pkg::STATUS_MISS);
  check_word("o_snoop_resp.be", {16'd0, snoop_resp.be}, 32'h0000_0000);
  load_read(line_b_addr);
  check_status("o_load_resp.status", load_resp.status, l1d_cache_pkg::STATUS_HIT);
  check_way("o_load_resp.hit_way", load_resp.hit_way, 2'b01);
  check_line("o_load_resp.line", load_resp.line, line_b_data);
endtask

//--- tests/l1d_tb.sv
/*
 * L1D front end testbench
 * Drives the load, walker, snoop and refill ports of the cache front end
 * and compares every response against values derived from the stimulus
 */
`timescale 1ns/1ps
`include "l1d_config.svh"

module l1d_tb;

  localparam int TIMEOUT_CYCLES  = 400;
  localparam int REFILL_WAIT_MAX = 16;

  logic                       clk;
  logic                       reset_n;
  l1d_cache_pkg::rd_req_t     load_req;
  l1d_cache_pkg::rd_resp_t    load_resp;
  l1d_snoop_pkg::ptw_req_t    ptw_req;
  l1d_snoop_pkg::ptw_resp_t   ptw_resp;
  l1d_snoop_pkg::snoop_req_t  snoop_req;
  l1d_snoop_pkg::snoop_resp_t snoop_resp;
  logic                       refill_valid;
  l1d_cache_pkg::wr_req_t     refill;
  logic                       refill_ready;

  logic [31:0] lcg_state;
  int          cycle_count;

  // Lines shared between the directed tests
  l1d_cache_pkg::paddr_t line_a_addr;
  l1d_cache_pkg::line_t  line_a_data;

  l1d_top dut0 (
    .i_clk          (clk),
    .i_reset_n      (reset_n),
    .i_load_req     (load_req),
    .o_load_resp    (load_resp),
    .i_ptw_req      (ptw_req),
    .o_ptw_resp     (ptw_resp),
    .i_snoop_req    (snoop_req),
    .o_snoop_resp   (snoop_resp),
    .i_refill_valid (refill_valid),
    .i_refill       (refill),
    .o_refill_ready (refill_ready)
  );

  always #4 clk = ~clk;

  // Limit well above the length of the directed tests
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      fail_run("Timeout: the run did not finish within the cycle limit");
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_status(input string name, input l1d_cache_pkg::status_e got,
                              input l1d_cache_pkg::status_e exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s got %s expected %s",
                         $time, name, got.name(), exp.name()));
    end
  endtask

  task automatic check_line(input string name, input l1d_cache_pkg::line_t got,
                            input l1d_cache_pkg::line_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [`L1D_XLEN_W-1:0] got,
                            input logic [`L1D_XLEN_W-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_way(input string name, input l1d_cache_pkg::way_oh_t got,
                           input l1d_cache_pkg::way_oh_t exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("FAILED at %0t: %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  function automatic l1d_cache_pkg::rd_req_t make_rd(input l1d_cache_pkg::paddr_t addr);
    l1d_cache_pkg::rd_req_t r;
    r.valid = 1'b1;
    r.paddr = addr;
    return r;
  endfunction

  function automatic l1d_snoop_pkg::ptw_req_t make_ptw(input l1d_cache_pkg::paddr_t addr);
    l1d_snoop_pkg::ptw_req_t r;
    r.valid = 1'b1;
    r.paddr = addr;
    return r;
  endfunction

  function automatic l1d_snoop_pkg::snoop_req_t make_snoop(
      input l1d_snoop_pkg::snoop_cmd_e cmd, input l1d_cache_pkg::paddr_t addr,
      input l1d_cache_pkg::way_oh_t way);
    l1d_snoop_pkg::snoop_req_t r;
    r.valid = 1'b1;
    r.cmd   = cmd;
    r.paddr = addr;
    r.way   = way;
    return r;
  endfunction

  function automatic l1d_cache_pkg::wr_req_t make_refill(
      input l1d_cache_pkg::paddr_t addr, input l1d_cache_pkg::way_oh_t way,
      input l1d_cache_pkg::line_t data);
    l1d_cache_pkg::wr_req_t r;
    r.paddr      = addr;
    r.way        = way;
    r.data       = data;
    r.line_valid = 1'b1;
    return r;
  endfunction

  // ----------------------------------------
  // Drivers
  // ----------------------------------------
  // Request at s0, then stop at the middle of s1 where responses are stable
  task automatic issue_reads(input l1d_snoop_pkg::snoop_req_t s,
                             input l1d_snoop_pkg::ptw_req_t p,
                             input l1d_cache_pkg::rd_req_t l);
    @(posedge clk);
    snoop_req <= s;
    ptw_req   <= p;
    load_req  <= l;
    @(posedge clk);
    snoop_req <= '0;
    ptw_req   <= '0;
    load_req  <= '0;
    @(negedge clk);
    check_bit("o_snoop_resp.valid", snoop_resp.valid, s.valid);
    check_bit("o_ptw_resp.valid", ptw_resp.valid, p.valid);
  endtask

  task automatic load_read(input l1d_cache_pkg::paddr_t addr);
    issue_reads('0, '0, make_rd(addr));
  endtask

  task automatic ptw_read(input l1d_cache_pkg::paddr_t addr);
    issue_reads('0, make_ptw(addr), '0);
  endtask

  task automatic snoop_read(input l1d_cache_pkg::paddr_t addr);
    issue_reads(make_snoop(l1d_snoop_pkg::SNOOP_READ, addr, '0), '0, '0);
  endtask

  task automatic start_refill(input l1d_cache_pkg::wr_req_t w);
    @(posedge clk);
    refill_valid <= 1'b1;
    refill       <= w;
    @(negedge clk);
  endtask

  // Hold the refill until a cycle with ready high, it transfers at the next edge
  task automatic finish_refill();
    int waited;
    waited = 0;
    while (!refill_ready) begin
      if (waited == REFILL_WAIT_MAX) begin
        fail_run("Refill request was never accepted by the cache");
      end
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    refill_valid <= 1'b0;
  endtask

  `include "l1d_tests.svh"

  initial begin
    clk          = 1'b0;
    reset_n      = 1'b0;
    load_req     = '0;
    ptw_req      = '0;
    snoop_req    = '0;
    refill_valid = 1'b0;
    refill       = '0;
    lcg_state    = 32'h6e803e05;
    cycle_count  = 0;
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;

    test_reset_state();
    test_refill_then_load();
    test_walker_word();
    test_arbitration();
    test_invalidate_refill();

    $display("All checks passed");
    $finish;
  end

endmodule

//--- l1d_front.f
+incdir+verilog
+incdir+tests
verilog/l1d_cache_pkg.sv
verilog/l1d_snoop_pkg.sv
verilog/l1d_rd_arbiter.sv
verilog/l1d_array.sv
verilog/l1d_ptw_access.sv
verilog/l1d_snoop_unit.sv
verilog/l1d_top.sv
tests/l1d_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the L1D front end testbench with Verilator and run it
verilator --binary --timing --assert --timescale 1ns/1ps \
  -f l1d_front.f --top-module l1d_tb -o l1d_sim \
  && ./obj_dir/l1d_sim | tee /dev/stderr | grep -q "All checks passed" \
  && echo "Simulation PASS" \
  || { echo "Simulation FAIL"; exit 1; }
